/* gateway_pkg.sv */
`default_nettype none

// shared widths, address map and message format for the gateway
package gateway_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // physical address and one data word
  localparam int paddr_width_lp = 28;
  localparam int data_width_lp  = 64;

  // one finish flag per core
  localparam int num_core_lp = 4;

  // byte offset bits inside one data word
  localparam int word_offset_lp = $clog2(data_width_lp / 8);

  ////////////////////////////////////////
  // address map
  ////////////////////////////////////////

  // everything below this goes to the host
  localparam logic [paddr_width_lp-1:0] dram_base_addr_lp = 28'h080_0000;

  // finish word of core n sits at base + 8*n
  // a read of the base itself returns the finish vector
  localparam logic [paddr_width_lp-1:0] host_finish_base_lp = 28'h010_2000;

  ////////////////////////////////////////
  // dram model
  ////////////////////////////////////////

  // 256 words that wrap inside the window
  localparam int dram_words_lp     = 256;
  localparam int dram_idx_width_lp = $clog2(dram_words_lp);

  // cycles from acceptance to response valid
  localparam int dram_latency_lp   = 15;
  localparam int dram_cnt_width_lp = $clog2(dram_latency_lp);

  ////////////////////////////////////////
  // memory messages
  ////////////////////////////////////////

  typedef enum logic
  {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_op_e;

  // same layout for commands and responses
  // write response echoes op and addr, data is zero
  typedef struct packed
  {
    mem_op_e                   op;
    logic [paddr_width_lp-1:0] addr;
    logic [data_width_lp-1:0]  data;
  } mem_msg_s;

endpackage

`default_nettype wire

/* gateway_cmd_router.sv */
`timescale 1ns/1ps
`default_nettype none

// steers one command port to dram or host by address
// merges both response streams back onto one port
module gateway_cmd_router
  import gateway_pkg::*;
  (
    input  logic     blackparrot_clk,
    input  logic     arst_n_i,

    // core side
    input  mem_msg_s cmd_i,
    input  logic     cmd_v_i,
    output logic     cmd_ready_o,

    output mem_msg_s resp_o,
    output logic     resp_v_o,
    input  logic     resp_yumi_i,

    // dram side
    output mem_msg_s dram_cmd_o,
    output logic     dram_cmd_v_o,
    input  logic     dram_cmd_ready_i,
    input  mem_msg_s dram_resp_i,
    input  logic     dram_resp_v_i,
    output logic     dram_resp_yumi_o,

    // host side
    output mem_msg_s host_cmd_o,
    output logic     host_cmd_v_o,
    input  logic     host_cmd_ready_i,
    input  mem_msg_s host_resp_i,
    input  logic     host_resp_v_i,
    output logic     host_resp_yumi_o
  );

  logic outstanding_r;
  logic to_host;
  logic cmd_fire;
  logic resp_fire;

  ////////////////////////////////////////
  // command steering
  ////////////////////////////////////////

  // anything under the dram window is a host access
  assign to_host = (cmd_i.addr < dram_base_addr_lp);

  // payload fans out, only one valid is raised
  assign dram_cmd_o   = cmd_i;
  assign host_cmd_o   = cmd_i;
  assign dram_cmd_v_o = cmd_v_i & ~to_host & ~outstanding_r;
  assign host_cmd_v_o = cmd_v_i & to_host & ~outstanding_r;

  // ready follows the chosen target
  assign cmd_ready_o = ~outstanding_r & (to_host ? host_cmd_ready_i : dram_cmd_ready_i);

  ////////////////////////////////////////
  // response merge
  ////////////////////////////////////////

  // at most one target answers at a time
  assign resp_o   = host_resp_v_i ? host_resp_i : dram_resp_i;
  assign resp_v_o = host_resp_v_i | dram_resp_v_i;

  // yumi goes back only to the one that answered
  assign host_resp_yumi_o = resp_yumi_i & host_resp_v_i;
  assign dram_resp_yumi_o = resp_yumi_i & dram_resp_v_i & ~host_resp_v_i;

  assign cmd_fire  = cmd_v_i & cmd_ready_o;
  assign resp_fire = resp_v_o & resp_yumi_i;

  // one request in flight
  // set at acceptance, cleared when the response is taken
  always_ff @(posedge blackparrot_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      outstanding_r <= 1'b0;
    end
    else if (cmd_fire)
    begin
      outstanding_r <= 1'b1;
    end
    else if (resp_fire)
    begin
      outstanding_r <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* gateway_dram.sv */
`timescale 1ns/1ps
`default_nettype none

// fixed latency word memory
// unwritten words read back as zero
module gateway_dram
  import gateway_pkg::*;
  (
    input  logic     blackparrot_clk,
    input  logic     arst_n_i,

    input  mem_msg_s cmd_i,
    input  logic     cmd_v_i,
    output logic     cmd_ready_o,

    output mem_msg_s resp_o,
    output logic     resp_v_o,
    input  logic     resp_yumi_i
  );

  // storage and per word written bits
  logic [data_width_lp-1:0] mem_r [dram_words_lp];
  logic [dram_words_lp-1:0] written_r;

  logic [dram_idx_width_lp-1:0] cmd_idx;
  logic [data_width_lp-1:0]     rd_data;

  // in flight tracking
  logic                         busy_r;
  logic [dram_cnt_width_lp-1:0] cnt_r;
  mem_msg_s                     resp_r;

  logic cmd_fire;
  logic resp_fire;

  ////////////////////////////////////////
  // decode and handshake
  ////////////////////////////////////////

  // word index from the low address bits
  // upper address bits just wrap
  assign cmd_idx = cmd_i.addr[word_offset_lp +: dram_idx_width_lp];

  // zero until first write
  assign rd_data = written_r[cmd_idx] ? mem_r[cmd_idx] : '0;

  // one command at a time
  assign cmd_ready_o = ~busy_r;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;

  // valid once the count has run out, held until yumi
  assign resp_v_o  = busy_r & (cnt_r == '0);
  assign resp_o    = resp_r;
  assign resp_fire = resp_v_o & resp_yumi_i;

  ////////////////////////////////////////
  // latency counter
  ////////////////////////////////////////

  // loaded with latency-1 so valid shows up
  // latency cycles after the acceptance cycle
  always_ff @(posedge blackparrot_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      busy_r <= 1'b0;
      cnt_r  <= '0;
    end
    else if (cmd_fire)
    begin
      busy_r <= 1'b1;
      cnt_r  <= dram_cnt_width_lp'(dram_latency_lp - 1);
    end
    else if (resp_fire)
    begin
      busy_r <= 1'b0;
    end
    else if (busy_r && (cnt_r != '0))
    begin
      cnt_r <= cnt_r - 1'b1;
    end
  end

  // written bits, cleared at reset
  always_ff @(posedge blackparrot_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      written_r <= '0;
    end
    else if (cmd_fire && (cmd_i.op == e_mem_wr))
    begin
      written_r[cmd_idx] <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // storage and response payload
  ////////////////////////////////////////

  always_ff @(posedge blackparrot_clk)
  begin
    if (cmd_fire && (cmd_i.op == e_mem_wr))
    begin
      mem_r[cmd_idx] <= cmd_i.data;
    end
  end

  // response captured at acceptance
  // write acks carry zero data
  always_ff @(posedge blackparrot_clk)
  begin
    if (cmd_fire)
    begin
      resp_r.op   <= cmd_i.op;
      resp_r.addr <= cmd_i.addr;
      resp_r.data <= (cmd_i.op == e_mem_rd) ? rd_data : '0;
    end
  end

endmodule

`default_nettype wire

/* gateway_host.sv */
`timescale 1ns/1ps
`default_nettype none

// host device with per core finish flags
// answers every access one cycle later
module gateway_host
  import gateway_pkg::*;
  (
    input  logic                   blackparrot_clk,
    input  logic                   arst_n_i,

    input  mem_msg_s               cmd_i,
    input  logic                   cmd_v_i,
    output logic                   cmd_ready_o,

    output mem_msg_s               resp_o,
    output logic                   resp_v_o,
    input  logic                   resp_yumi_i,

    output logic [num_core_lp-1:0] program_finish_o,
    output logic                   done_o
  );

  logic [num_core_lp-1:0] finish_r;
  logic [num_core_lp-1:0] finish_hit;
  logic                   resp_v_r;
  mem_msg_s               resp_r;

  logic cmd_fire;
  logic resp_fire;

  // blocked while a response waits
  assign cmd_ready_o = ~resp_v_r;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;
  assign resp_fire   = resp_v_r & resp_yumi_i;

  ////////////////////////////////////////
  // finish word decode
  ////////////////////////////////////////

  // core n owns the word at base + 8*n
  always_comb
  begin
    for (int n = 0; n < num_core_lp; n++)
    begin
      finish_hit[n] = cmd_fire & (cmd_i.op == e_mem_wr)
                    & (cmd_i.addr == host_finish_base_lp
                                     + paddr_width_lp'(n << word_offset_lp));
    end
  end

  // sticky until reset
  // writes elsewhere in host space are dropped
  always_ff @(posedge blackparrot_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      finish_r <= '0;
      resp_v_r <= 1'b0;
    end
    else
    begin
      finish_r <= finish_r | finish_hit;
      if (cmd_fire)
      begin
        resp_v_r <= 1'b1;
      end
      else if (resp_fire)
      begin
        resp_v_r <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // response payload
  ////////////////////////////////////////

  // base read gives the flag vector, anything else reads zero
  always_ff @(posedge blackparrot_clk)
  begin
    if (cmd_fire)
    begin
      resp_r.op   <= cmd_i.op;
      resp_r.addr <= cmd_i.addr;
      if ((cmd_i.op == e_mem_rd) && (cmd_i.addr == host_finish_base_lp))
      begin
        resp_r.data <= data_width_lp'(finish_r);
      end
      else
      begin
        resp_r.data <= '0;
      end
    end
  end

  assign resp_o   = resp_r;
  assign resp_v_o = resp_v_r;

  // done once every core has checked in
  assign program_finish_o = finish_r;
  assign done_o           = &finish_r;

endmodule

`default_nettype wire

/* gateway_top.sv */
`timescale 1ns/1ps
`default_nettype none

// memory side of the gateway
// router in front of the dram model and the host device
module gateway_top
  import gateway_pkg::*;
  (
    input  logic                   blackparrot_clk,
    input  logic                   arst_n_i,

    input  mem_msg_s               cmd_i,
    input  logic                   cmd_v_i,
    output logic                   cmd_ready_o,

    output mem_msg_s               resp_o,
    output logic                   resp_v_o,
    input  logic                   resp_yumi_i,

    output logic [num_core_lp-1:0] program_finish_o,
    output logic                   done_o
  );

  ////////////////////////////////////////
  // router to target wires
  ////////////////////////////////////////

  // dram path
  mem_msg_s dram_cmd;
  logic     dram_cmd_v;
  logic     dram_cmd_ready;
  mem_msg_s dram_resp;
  logic     dram_resp_v;
  logic     dram_resp_yumi;

  // host path
  mem_msg_s host_cmd;
  logic     host_cmd_v;
  logic     host_cmd_ready;
  mem_msg_s host_resp;
  logic     host_resp_v;
  logic     host_resp_yumi;

  gateway_cmd_router gateway_cmd_router_i
  (
    .blackparrot_clk  (blackparrot_clk),
    .arst_n_i         (arst_n_i),
    .cmd_i            (cmd_i),
    .cmd_v_i          (cmd_v_i),
    .cmd_ready_o      (cmd_ready_o),
    .resp_o           (resp_o),
    .resp_v_o         (resp_v_o),
    .resp_yumi_i      (resp_yumi_i),
    .dram_cmd_o       (dram_cmd),
    .dram_cmd_v_o     (dram_cmd_v),
    .dram_cmd_ready_i (dram_cmd_ready),
    .dram_resp_i      (dram_resp),
    .dram_resp_v_i    (dram_resp_v),
    .dram_resp_yumi_o (dram_resp_yumi),
    .host_cmd_o       (host_cmd),
    .host_cmd_v_o     (host_cmd_v),
    .host_cmd_ready_i (host_cmd_ready),
    .host_resp_i      (host_resp),
    .host_resp_v_i    (host_resp_v),
    .host_resp_yumi_o (host_resp_yumi)
  );

  // fixed latency memory above dram_base_addr_lp
  gateway_dram gateway_dram_i
  (
    .blackparrot_clk (blackparrot_clk),
    .arst_n_i        (arst_n_i),
    .cmd_i           (dram_cmd),
    .cmd_v_i         (dram_cmd_v),
    .cmd_ready_o     (dram_cmd_ready),
    .resp_o          (dram_resp),
    .resp_v_o        (dram_resp_v),
    .resp_yumi_i     (dram_resp_yumi)
  );

  // finish flags and done level
  gateway_host gateway_host_i
  (
    .blackparrot_clk  (blackparrot_clk),
    .arst_n_i         (arst_n_i),
    .cmd_i            (host_cmd),
    .cmd_v_i          (host_cmd_v),
    .cmd_ready_o      (host_cmd_ready),
    .resp_o           (host_resp),
    .resp_v_o         (host_resp_v),
    .resp_yumi_i      (host_resp_yumi),
    .program_finish_o (program_finish_o),
    .done_o           (done_o)
  );

endmodule

`default_nettype wire

/* tb_gateway_top.sv */
`timescale 1ns/1ps
`default_nettype none

// stands in for the core on the gateway command port
module tb_gateway_top
  import gateway_pkg::*;
  ();

  localparam int clk_period_lp   = 40;
  localparam int num_random_lp   = 40;
  localparam int max_yumi_dly_lp = 3;
  // unwritten read, wrap pair, random mix, host traffic
  localparam int num_txn_lp = 1 + 2 + num_random_lp + 2 + 2 * num_core_lp;
  localparam int timeout_cycles_lp = num_txn_lp * (dram_latency_lp + max_yumi_dly_lp + 4) + 100;

  logic                   blackparrot_clk = 1'b0;
  logic                   arst_n_i;
  mem_msg_s               cmd_i;
  logic                   cmd_v_i;
  logic                   cmd_ready_o;
  mem_msg_s               resp_o;
  logic                   resp_v_o;
  logic                   resp_yumi_i;
  logic [num_core_lp-1:0] program_finish_o;
  logic                   done_o;

  // reference model
  // missing keys read as zero
  logic [data_width_lp-1:0] model_mem [int];
  logic [num_core_lp-1:0]   model_finish;
  mem_msg_s                 exp_msg;
  int                       exp_lat;
  int                       acc_cyc;
  int                       cyc;
  logic                     pending;

  int          errors;
  int          txn_count;
  int unsigned lcg_state;
  string       test_name;

  gateway_top gateway_top_i
  (
    .blackparrot_clk  (blackparrot_clk),
    .arst_n_i         (arst_n_i),
    .cmd_i            (cmd_i),
    .cmd_v_i          (cmd_v_i),
    .cmd_ready_o      (cmd_ready_o),
    .resp_o           (resp_o),
    .resp_v_o         (resp_v_o),
    .resp_yumi_i      (resp_yumi_i),
    .program_finish_o (program_finish_o),
    .done_o           (done_o)
  );

  always #(clk_period_lp / 2) blackparrot_clk = ~blackparrot_clk;

  ////////////////////////////////////////
  // model helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    // low bits of an lcg cycle too fast
    return lcg_state >> 8;
  endfunction

  // finish word of core n at base + 8*n
  function automatic logic [num_core_lp-1:0] finish_bits(input logic [paddr_width_lp-1:0] addr);
    logic [num_core_lp-1:0] bits;
    bits = '0;
    for (int n = 0; n < num_core_lp; n++)
    begin
      if (addr == host_finish_base_lp + paddr_width_lp'(8 * n))
      begin
        bits[n] = 1'b1;
      end
    end
    return bits;
  endfunction

  // op and addr echoed, data only on reads
  function automatic mem_msg_s expected_resp(input mem_msg_s cmd);
    mem_msg_s r;
    int       idx;
    r.op   = cmd.op;
    r.addr = cmd.addr;
    r.data = '0;
    // dram word index is addr 10..3
    idx = int'(cmd.addr[10:3]);
    if (cmd.op == e_mem_rd)
    begin
      if (cmd.addr >= dram_base_addr_lp)
      begin
        if (model_mem.exists(idx))
        begin
          r.data = model_mem[idx];
        end
      end
      else if (cmd.addr == host_finish_base_lp)
      begin
        r.data = data_width_lp'(model_finish);
      end
    end
    return r;
  endfunction

  ////////////////////////////////////////
  // acceptance monitor
  ////////////////////////////////////////

  always @(posedge blackparrot_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      cyc          <= 0;
      acc_cyc      <= 0;
      exp_lat      <= 0;
      exp_msg      <= '0;
      pending      <= 1'b0;
      model_finish <= '0;
    end
    else
    begin
      cyc <= cyc + 1;
      if (cmd_v_i && cmd_ready_o)
      begin
        pending <= 1'b1;
        acc_cyc <= cyc;
        exp_lat <= (cmd_i.addr < dram_base_addr_lp) ? 1 : dram_latency_lp;
        exp_msg <= expected_resp(cmd_i);
        // model word updated after the expected read data was taken
        if (cmd_i.op == e_mem_wr && cmd_i.addr >= dram_base_addr_lp)
        begin
          model_mem[int'(cmd_i.addr[10:3])] = cmd_i.data;
        end
        else if (cmd_i.op == e_mem_wr)
        begin
          model_finish <= model_finish | finish_bits(cmd_i.addr);
        end
      end
      else if (resp_v_o && resp_yumi_i)
      begin
        pending <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // first edge out of reset
  assert property (@(posedge blackparrot_clk) $rose(arst_n_i) |->
    cmd_ready_o && !resp_v_o && (program_finish_o == '0) && !done_o)
  else
  begin
    errors++;
    $display("Error %s expected ready 1 valid 0 finish 0 done 0 actual %b %b %b %b", test_name,
             $sampled(cmd_ready_o), $sampled(resp_v_o), $sampled(program_finish_o),
             $sampled(done_o));
  end

  // cycles from acceptance edge to first valid edge
  assert property (@(posedge blackparrot_clk) disable iff (!arst_n_i)
    $rose(resp_v_o) |-> (cyc - acc_cyc) == exp_lat)
  else
  begin
    errors++;
    $display("Error %s latency expected %0d actual %0d", test_name, $sampled(exp_lat),
             $sampled(cyc - acc_cyc));
  end

  assert property (@(posedge blackparrot_clk) disable iff (!arst_n_i)
    resp_v_o |-> resp_o == exp_msg)
  else
  begin
    errors++;
    $display("Error %s response expected %h actual %h", test_name, $sampled(exp_msg),
             $sampled(resp_o));
  end

  // single outstanding request
  assert property (@(posedge blackparrot_clk) disable iff (!arst_n_i)
    pending |-> !cmd_ready_o)
  else
  begin
    errors++;
    $display("command port was ready while a request was outstanding in test %s", test_name);
  end

  assert property (@(posedge blackparrot_clk) disable iff (!arst_n_i)
    resp_v_o |-> pending)
  else
  begin
    errors++;
    $display("a response appeared with no request outstanding in test %s", test_name);
  end

  assert property (@(posedge blackparrot_clk) disable iff (!arst_n_i)
    resp_v_o && !resp_yumi_i |=> resp_v_o && $stable(resp_o))
  else
  begin
    errors++;
    $display("response dropped or changed before yumi in test %s", test_name);
  end

  assert property (@(posedge blackparrot_clk) disable iff (!arst_n_i)
    program_finish_o == model_finish)
  else
  begin
    errors++;
    $display("Error %s finish expected %b actual %b", test_name, $sampled(model_finish),
             $sampled(program_finish_o));
  end

  assert property (@(posedge blackparrot_clk) disable iff (!arst_n_i)
    done_o == &model_finish)
  else
  begin
    errors++;
    $display("Error %s done expected %b actual %b", test_name, $sampled(&model_finish),
             $sampled(done_o));
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  // one command, wait for its response, take it dly cycles later
  task automatic transact(input mem_op_e op, input logic [paddr_width_lp-1:0] addr,
                          input logic [data_width_lp-1:0] data, input int dly);
    cmd_i   = '{op: op, addr: addr, data: data};
    cmd_v_i = 1'b1;
    #1;
    while (!cmd_ready_o)
    begin
      @(posedge blackparrot_clk);
      #3;
    end
    @(posedge blackparrot_clk);
    #2;
    cmd_v_i = 1'b0;
    while (!resp_v_o)
    begin
      @(posedge blackparrot_clk);
      #2;
    end
    repeat (dly)
    begin
      @(posedge blackparrot_clk);
      #2;
    end
    resp_yumi_i = 1'b1;
    @(posedge blackparrot_clk);
    #2;
    resp_yumi_i = 1'b0;
    txn_count++;
  endtask

  initial
  begin
    int          order [num_core_lp];
    int          j;
    int          tmp;
    logic [31:0] r;
    arst_n_i    = 1'b0;
    cmd_i       = '0;
    cmd_v_i     = 1'b0;
    resp_yumi_i = 1'b0;
    errors      = 0;
    txn_count   = 0;
    lcg_state   = 14016;
    test_name   = "reset";
    repeat (3) @(posedge blackparrot_clk);
    #2;
    arst_n_i = 1'b1;
    @(posedge blackparrot_clk);
    #2;

    test_name = "unwritten";
    r = next_random();
    transact(e_mem_rd, dram_base_addr_lp + paddr_width_lp'({r[7:0], 3'b000}), '0, 0);

    // 0x828 lands on the same word as 0x028
    test_name = "wrap";
    transact(e_mem_wr, dram_base_addr_lp + 28'h028, 64'h0123_4567_89ab_cdef, 1);
    transact(e_mem_rd, dram_base_addr_lp + 28'h828, '0, 2);

    // 32 words, alias bits 13..11 random
    test_name = "dram_random";
    for (int i = 0; i < num_random_lp; i++)
    begin
      r = next_random();
      transact(r[20] ? e_mem_wr : e_mem_rd,
               dram_base_addr_lp + paddr_width_lp'({r[13:11], 3'b000, r[4:0], 3'b000}),
               {next_random(), next_random()}, int'(r[22:21]));
    end

    test_name = "host_other";
    transact(e_mem_wr, host_finish_base_lp + 28'h100, 64'hffff, 0);
    transact(e_mem_rd, host_finish_base_lp + 28'h040, '0, 1);

    // finish words in shuffled core order
    test_name = "host_finish";
    for (int i = 0; i < num_core_lp; i++)
    begin
      order[i] = i;
    end
    for (int i = num_core_lp - 1; i > 0; i--)
    begin
      r        = next_random();
      j        = int'(r % (i + 1));
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    foreach (order[k])
    begin
      r = next_random();
      transact(e_mem_wr, host_finish_base_lp + paddr_width_lp'(8 * order[k]), 64'(r),
               int'(r[1:0]));
      transact(e_mem_rd, host_finish_base_lp, '0, 0);
    end

    repeat (2) @(posedge blackparrot_clk);
    $display("transactions %0d errors %0d", txn_count, errors);
    if (errors == 0)
    begin
      $display("TEST RESULT: PASS");
    end
    else
    begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // hang guard sized from the transaction count
  initial
  begin
    #(timeout_cycles_lp * clk_period_lp);
    $display("watchdog expired after %0d cycles, the DUT stopped responding", timeout_cycles_lp);
    $display("transactions %0d errors %0d", txn_count, errors);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* gateway_top.f */
gateway_pkg.sv
gateway_cmd_router.sv
gateway_dram.sv
gateway_host.sv
gateway_top.sv
tb_gateway_top.sv
